/* rtl/obj_pkg.sv */
package obj_pkg;

    // field widths of the sprite list format
    localparam int WORD_W  = 16;
    localparam int TILE_W  = 13;
    localparam int COORD_W = 12;
    localparam int ZOOM_W  = 8;
    localparam int COLOR_W = 8;
    localparam int COUNT_W = 5;

    // one zoom step per source pixel of a 16x16 tile
    localparam int ZOOM_STEPS  = 16;
    localparam int ENTRY_WORDS = 8;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [COORD_W-1:0] coord_t;

    // one sprite list entry after field split
    typedef struct packed {
        logic [TILE_W-1:0]  tile_code;
        logic [ZOOM_W-1:0]  x_zoom;
        logic [ZOOM_W-1:0]  y_zoom;
        coord_t             x;
        coord_t             y;
        // upper nibble of the x word
        logic               latch_extra;
        logic               latch_master;
        logic               use_extra;
        logic               use_scroll;
        logic               is_cmd;
        logic [COLOR_W-1:0] colour;
        logic               flip_x;
        logic               flip_y;
        // sequence and latch flags from the colour word
        logic               reuse_color;
        logic               next_seq;
        logic               use_latch_y;
        logic               inc_y;
        logic               use_latch_x;
        logic               inc_x;
    } obj_entry_t;

    // state set by a command entry, held until the next command
    typedef struct packed {
        logic disabled;
        logic flipscreen;
        logic bpp6;
    } obj_ctrl_t;

    typedef struct packed {
        logic [TILE_W-1:0]  tile_code;
        logic [COLOR_W-1:0] colour;
        logic               flip_x;
        logic               flip_y;
        coord_t             pos_x;
        coord_t             pos_y;
        obj_ctrl_t          ctrl;
    } obj_eval_t;

    typedef struct packed {
        logic [ZOOM_STEPS-1:0] row_mask;
        logic [ZOOM_STEPS-1:0] col_mask;
        logic [COUNT_W-1:0]    row_count;
        logic [COUNT_W-1:0]    col_count;
    } obj_zoom_t;

    // descriptor handed to a tile renderer
    typedef struct packed {
        logic               visible;
        logic [TILE_W-1:0]  tile_code;
        logic [COLOR_W-1:0] colour;
        coord_t             screen_x;
        coord_t             screen_y;
        logic               flip_x;
        logic               flip_y;
        logic               bpp6;
    } obj_draw_t;

endpackage

/* rtl/obj_entry_decode.sv */
module obj_entry_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_start,
    input  logic                word_strobe,
    input  obj_pkg::word_t      word_data,
    output logic                entry_valid,
    output obj_pkg::obj_entry_t entry,
    output obj_pkg::obj_ctrl_t  ctrl
);
    import obj_pkg::*;

    localparam int IDX_W = $clog2(ENTRY_WORDS);

    word_t            words [ENTRY_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             last_word;
    obj_entry_t       dec;

    assign last_word = word_strobe && !frame_start &&
                       (word_idx == IDX_W'(ENTRY_WORDS - 1));

    // field split of the buffered words, 6 and 7 carry nothing
    always_comb begin
        dec.tile_code    = words[0][TILE_W-1:0];
        dec.x_zoom       = words[1][7:0];
        dec.y_zoom       = words[1][15:8];
        dec.x            = words[2][COORD_W-1:0];
        dec.latch_extra  = words[2][12];
        dec.latch_master = words[2][13];
        // the two scroll enables are stored active low
        dec.use_extra    = ~words[2][14];
        dec.use_scroll   = ~words[2][15];
        dec.y            = words[3][COORD_W-1:0];
        dec.is_cmd       = words[3][15];
        dec.colour       = words[4][COLOR_W-1:0];
        dec.flip_x       = words[4][8];
        dec.flip_y       = words[4][9];
        dec.reuse_color  = words[4][10];
        dec.next_seq     = words[4][11];
        dec.use_latch_y  = words[4][12];
        dec.inc_y        = words[4][13];
        dec.use_latch_x  = words[4][14];
        dec.inc_x        = words[4][15];
    end

    always_ff @(posedge clk) begin
        if (word_strobe) begin
            words[word_idx] <= word_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_idx    <= '0;
            entry_valid <= 1'b0;
            ctrl        <= '0;
        end else begin
            entry_valid <= last_word;
            if (frame_start) begin
                word_idx <= '0;
                ctrl     <= '0;
            end else if (word_strobe) begin
                // index wraps to zero after the eighth word
                word_idx <= word_idx + 1'b1;
                // word 3 is already buffered when the command word arrives
                if (word_idx == IDX_W'(5) && dec.is_cmd) begin
                    ctrl.disabled   <= word_data[12];
                    ctrl.flipscreen <= word_data[13];
                    ctrl.bpp6       <= word_data[8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last_word) begin
            entry <= dec;
        end
    end

endmodule

/* rtl/obj_position_eval.sv */
module obj_position_eval (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          frame_start,
    input  logic                          entry_valid,
    input  obj_pkg::obj_entry_t           entry,
    input  obj_pkg::obj_ctrl_t            ctrl,
    input  logic [obj_pkg::COUNT_W-1:0]   row_count,
    input  logic [obj_pkg::COUNT_W-1:0]   col_count,
    output logic                          zoom_start_row,
    output logic                          zoom_start_col,
    output logic                          zoom_cont_row,
    output logic                          zoom_cont_col,
    output logic [8:0]                    zoom_delta_row,
    output logic [8:0]                    zoom_delta_col,
    output logic                          eval_valid,
    output obj_pkg::obj_eval_t            eval
);
    import obj_pkg::*;

    coord_t             master_x;
    coord_t             master_y;
    coord_t             extra_x;
    coord_t             extra_y;
    coord_t             scroll_x;
    coord_t             scroll_y;
    coord_t             base_x;
    coord_t             base_y;
    coord_t             pos_x;
    coord_t             pos_y;
    logic [COLOR_W-1:0] colour_q;
    logic [TILE_W-1:0]  tile_q;
    logic               flip_x_q;
    logic               flip_y_q;
    obj_ctrl_t          ctrl_q;
    logic               prev_seq;
    logic               seq_start;
    logic               pos_step;

    // scroll offset of the current entry
    always_comb begin
        scroll_x = '0;
        scroll_y = '0;
        if (entry.use_scroll) begin
            scroll_x = master_x;
            scroll_y = master_y;
            if (entry.use_extra) begin
                scroll_x = scroll_x + extra_x;
                scroll_y = scroll_y + extra_y;
            end
        end
    end

    // cycle 1: sequence start and scroll latches
    always_ff @(posedge clk) begin
        if (reset) begin
            pos_step  <= 1'b0;
            prev_seq  <= 1'b0;
            seq_start <= 1'b0;
            master_x  <= '0;
            master_y  <= '0;
            extra_x   <= '0;
            extra_y   <= '0;
        end else begin
            pos_step <= entry_valid;
            if (entry_valid) begin
                seq_start <= ~prev_seq;
                prev_seq  <= entry.next_seq;
                if (entry.latch_master && !entry.use_scroll) begin
                    master_x <= entry.x;
                    master_y <= entry.y;
                end
                if (entry.latch_extra && !entry.use_extra) begin
                    extra_x <= entry.x;
                    extra_y <= entry.y;
                end
            end
            // extra scroll does not survive into a new list
            if (frame_start) begin
                extra_x <= '0;
                extra_y <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (entry_valid && !prev_seq) begin
            base_x <= entry.x + scroll_x;
            base_y <= entry.y + scroll_y;
        end
    end

    // cycle 2: zoom kick-off and the position and colour latches
    always_ff @(posedge clk) begin
        if (reset) begin
            eval_valid     <= 1'b0;
            zoom_start_row <= 1'b0;
            zoom_start_col <= 1'b0;
        end else begin
            eval_valid     <= pos_step;
            zoom_start_row <= pos_step;
            zoom_start_col <= pos_step && (seq_start || entry.inc_x);
        end
    end

    always_ff @(posedge clk) begin
        if (pos_step) begin
            if (seq_start) begin
                zoom_delta_row <= 9'h100 - {1'b0, entry.y_zoom};
                zoom_delta_col <= 9'h100 - {1'b0, entry.x_zoom};
            end
            zoom_cont_row <= entry.inc_y;
            zoom_cont_col <= entry.inc_x;

            // counts still belong to the previous entry here
            if (entry.use_latch_y) begin
                pos_y <= pos_y + coord_t'(row_count);
            end else begin
                pos_y <= base_y;
            end
            if (entry.use_latch_x || entry.inc_x) begin
                if (entry.inc_x) begin
                    pos_x <= pos_x + coord_t'(col_count);
                end
            end else begin
                pos_x <= base_x;
            end

            if (!entry.reuse_color) begin
                colour_q <= entry.colour;
            end
            tile_q   <= entry.tile_code;
            flip_x_q <= entry.flip_x;
            flip_y_q <= entry.flip_y;
            ctrl_q   <= ctrl;
        end
    end

    always_comb begin
        eval.tile_code = tile_q;
        eval.colour    = colour_q;
        eval.flip_x    = flip_x_q;
        eval.flip_y    = flip_y_q;
        eval.pos_x     = pos_x;
        eval.pos_y     = pos_y;
        eval.ctrl      = ctrl_q;
    end

endmodule

/* rtl/obj_zoom_calc.sv */
module obj_zoom_calc (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             cont,
    input  logic [8:0]                       delta,
    output logic                             ready,
    output logic [obj_pkg::COUNT_W-1:0]      count,
    output logic [obj_pkg::ZOOM_STEPS-1:0]   mask
);
    import obj_pkg::*;

    localparam int STEP_W = $clog2(ZOOM_STEPS);

    logic [8:0]        accum;
    logic [8:0]        accum_next;
    logic [STEP_W-1:0] step;
    logic              carry;

    assign accum_next = accum + delta;
    // a pixel is kept whenever bit 8 flips
    assign carry      = accum_next[8] ^ accum[8];

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b1;
            step  <= '0;
            count <= '0;
        end else if (start) begin
            ready <= 1'b0;
            step  <= '0;
            count <= '0;
        end else if (!ready) begin
            step <= step + 1'b1;
            if (carry) begin
                count <= count + 1'b1;
            end
            if (step == STEP_W'(ZOOM_STEPS - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mask <= '0;
            // continued sequences keep the fractional phase
            if (!cont) begin
                accum <= '0;
            end
        end else if (!ready) begin
            accum <= accum_next;
            if (carry) begin
                mask[count[STEP_W-1:0]] <= 1'b1;
            end
        end
    end

endmodule

/* rtl/obj_draw_result.sv */
module obj_draw_result #(
    parameter int FLIP_X_ORIGIN = 496,
    parameter int FLIP_Y_ORIGIN = 240,
    parameter int X_LIMIT       = 480,
    parameter int Y_LIMIT       = 240
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             eval_valid,
    input  obj_pkg::obj_eval_t               eval,
    input  logic                             row_ready,
    input  logic                             col_ready,
    input  logic [obj_pkg::ZOOM_STEPS-1:0]   row_mask,
    input  logic [obj_pkg::ZOOM_STEPS-1:0]   col_mask,
    input  logic [obj_pkg::COUNT_W-1:0]      row_count,
    input  logic [obj_pkg::COUNT_W-1:0]      col_count,
    output logic                             draw_valid,
    output obj_pkg::obj_draw_t               draw,
    output obj_pkg::obj_zoom_t               zoom
);
    import obj_pkg::*;

    obj_eval_t held;
    obj_draw_t next_draw;
    logic      pending;
    logic      emit;

    // zoom drops ready the cycle after eval_valid, so pending never sees stale ready
    assign emit = pending && row_ready && col_ready;

    always_comb begin
        next_draw.visible   = (held.tile_code != '0) && !held.ctrl.disabled &&
                              (held.pos_x <= coord_t'(X_LIMIT)) &&
                              (held.pos_y <= coord_t'(Y_LIMIT));
        next_draw.tile_code = held.tile_code;
        next_draw.colour    = held.colour;
        next_draw.bpp6      = held.ctrl.bpp6;
        if (held.ctrl.flipscreen) begin
            next_draw.screen_x = coord_t'(FLIP_X_ORIGIN) - held.pos_x;
            next_draw.screen_y = coord_t'(FLIP_Y_ORIGIN) - held.pos_y;
            next_draw.flip_x   = ~held.flip_x;
            next_draw.flip_y   = ~held.flip_y;
        end else begin
            next_draw.screen_x = held.pos_x;
            next_draw.screen_y = held.pos_y;
            next_draw.flip_x   = held.flip_x;
            next_draw.flip_y   = held.flip_y;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= 1'b0;
            draw_valid <= 1'b0;
        end else begin
            draw_valid <= emit;
            if (eval_valid) begin
                pending <= 1'b1;
            end else if (emit) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (eval_valid) begin
            held <= eval;
        end
        if (emit) begin
            draw           <= next_draw;
            zoom.row_mask  <= row_mask;
            zoom.col_mask  <= col_mask;
            zoom.row_count <= row_count;
            zoom.col_count <= col_count;
        end
    end

endmodule

/* rtl/obj_engine_top.sv */
module obj_engine_top #(
    parameter int FLIP_X_ORIGIN = 496,
    parameter int FLIP_Y_ORIGIN = 240,
    parameter int X_LIMIT       = 480,
    parameter int Y_LIMIT       = 240
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_start,
    input  logic               word_strobe,
    input  obj_pkg::word_t     word_data,
    output logic               draw_valid,
    output obj_pkg::obj_draw_t draw,
    output obj_pkg::obj_zoom_t zoom
);
    import obj_pkg::*;

    logic                  entry_valid;
    obj_entry_t            entry;
    obj_ctrl_t             ctrl;
    logic                  eval_valid;
    obj_eval_t             eval;

    // links between position evaluation and the two zoom axes
    logic                  zoom_start_row;
    logic                  zoom_start_col;
    logic                  zoom_cont_row;
    logic                  zoom_cont_col;
    logic [8:0]            zoom_delta_row;
    logic [8:0]            zoom_delta_col;
    logic                  row_ready;
    logic                  col_ready;
    logic [COUNT_W-1:0]    row_count;
    logic [COUNT_W-1:0]    col_count;
    logic [ZOOM_STEPS-1:0] row_mask;
    logic [ZOOM_STEPS-1:0] col_mask;

    obj_entry_decode entry_decode (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .word_strobe (word_strobe),
        .word_data   (word_data),
        .entry_valid (entry_valid),
        .entry       (entry),
        .ctrl        (ctrl)
    );

    obj_position_eval position_eval (
        .clk            (clk),
        .reset          (reset),
        .frame_start    (frame_start),
        .entry_valid    (entry_valid),
        .entry          (entry),
        .ctrl           (ctrl),
        .row_count      (row_count),
        .col_count      (col_count),
        .zoom_start_row (zoom_start_row),
        .zoom_start_col (zoom_start_col),
        .zoom_cont_row  (zoom_cont_row),
        .zoom_cont_col  (zoom_cont_col),
        .zoom_delta_row (zoom_delta_row),
        .zoom_delta_col (zoom_delta_col),
        .eval_valid     (eval_valid),
        .eval           (eval)
    );

    obj_zoom_calc row_zoom (
        .clk   (clk),
        .reset (reset),
        .start (zoom_start_row),
        .cont  (zoom_cont_row),
        .delta (zoom_delta_row),
        .ready (row_ready),
        .count (row_count),
        .mask  (row_mask)
    );

    obj_zoom_calc col_zoom (
        .clk   (clk),
        .reset (reset),
        .start (zoom_start_col),
        .cont  (zoom_cont_col),
        .delta (zoom_delta_col),
        .ready (col_ready),
        .count (col_count),
        .mask  (col_mask)
    );

    obj_draw_result #(
        .FLIP_X_ORIGIN (FLIP_X_ORIGIN),
        .FLIP_Y_ORIGIN (FLIP_Y_ORIGIN),
        .X_LIMIT       (X_LIMIT),
        .Y_LIMIT       (Y_LIMIT)
    ) draw_result (
        .clk        (clk),
        .reset      (reset),
        .eval_valid (eval_valid),
        .eval       (eval),
        .row_ready  (row_ready),
        .col_ready  (col_ready),
        .row_mask   (row_mask),
        .col_mask   (col_mask),
        .row_count  (row_count),
        .col_count  (col_count),
        .draw_valid (draw_valid),
        .draw       (draw),
        .zoom       (zoom)
    );

endmodule

/* tests/obj_tb.sv */
module obj_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import obj_pkg::*;

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int STROBE_GAP   = 3;
    localparam int DRAW_TIMEOUT = 100;
    localparam int MAX_ITEMS    = 256;
    // eight words, eight draw fields, four zoom fields
    localparam int FIELDS       = 20;
    localparam int TOK_W        = 8 * 16;
    localparam int NAME_W       = 8 * 24;
    localparam int LINE_W       = 8 * 200;

    logic      clk;
    logic      reset;
    logic      frame_start;
    logic      word_strobe;
    word_t     word_data;
    logic      draw_valid;
    obj_draw_t draw;
    obj_zoom_t zoom;

    int draw_errors;
    int zoom_errors;
    int other_errors;
    int entries_run;

    obj_engine_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .word_strobe (word_strobe),
        .word_data   (word_data),
        .draw_valid  (draw_valid),
        .draw        (draw),
        .zoom        (zoom)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic send_word(input word_t value);
        @(posedge clk);
        #DRIVE_DELAY;
        word_data   = value;
        word_strobe = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        word_strobe = 1'b0;
        repeat (STROBE_GAP - 2) @(posedge clk);
    endtask

    task automatic pulse_frame();
        @(posedge clk);
        #DRIVE_DELAY;
        frame_start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        frame_start = 1'b0;
    endtask

    // descriptor outputs settle at the rising edge, so look at the falling one
    task automatic wait_draw(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DRAW_TIMEOUT) begin
            @(negedge clk);
            seen   = draw_valid;
            cycles = cycles + 1;
        end
    endtask

    task automatic compare_draw(input logic [NAME_W-1:0] name, input obj_draw_t expected,
                                input obj_draw_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0s draw expected %h actual %h", name, expected, actual);
            draw_errors++;
        end
    endtask

    task automatic compare_zoom(input logic [NAME_W-1:0] name, input obj_zoom_t expected,
                                input obj_zoom_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0s zoom expected %h actual %h", name, expected, actual);
            zoom_errors++;
        end
    endtask

    task automatic run_entry(input int fd);
        logic [NAME_W-1:0] name;
        logic [31:0]       vals [FIELDS];
        logic [31:0]       value;
        obj_draw_t         exp_draw;
        obj_zoom_t         exp_zoom;
        logic              seen;
        int                rc;
        int                got;
        name = '0;
        got  = 0;
        rc   = $fscanf(fd, "%s", name);
        for (int i = 0; i < FIELDS; i++) begin
            value = '0;
            rc    = $fscanf(fd, "%h", value);
            if (rc == 1) begin
                got++;
            end
            vals[i] = value;
        end
        if (got != FIELDS) begin
            $display("stimulus line for entry %0s has missing fields", name);
            other_errors++;
            return;
        end

        exp_draw.visible   = vals[8][0];
        exp_draw.tile_code = vals[9][TILE_W-1:0];
        exp_draw.colour    = vals[10][COLOR_W-1:0];
        exp_draw.screen_x  = vals[11][COORD_W-1:0];
        exp_draw.screen_y  = vals[12][COORD_W-1:0];
        exp_draw.flip_x    = vals[13][0];
        exp_draw.flip_y    = vals[14][0];
        exp_draw.bpp6      = vals[15][0];
        exp_zoom.row_mask  = vals[16][ZOOM_STEPS-1:0];
        exp_zoom.col_mask  = vals[17][ZOOM_STEPS-1:0];
        exp_zoom.row_count = vals[18][COUNT_W-1:0];
        exp_zoom.col_count = vals[19][COUNT_W-1:0];

        for (int i = 0; i < ENTRY_WORDS; i++) begin
            send_word(vals[i][WORD_W-1:0]);
        end
        wait_draw(seen);
        if (!seen) begin
            $display("no draw descriptor for entry %0s within %0d cycles", name, DRAW_TIMEOUT);
            other_errors++;
        end else begin
            compare_draw(name, exp_draw, draw);
            compare_zoom(name, exp_zoom, zoom);
        end
        entries_run++;
    endtask

    initial begin
        int                fd;
        int                rc;
        int                items;
        logic [TOK_W-1:0]  tok;
        logic [LINE_W-1:0] rest;
        reset        = 1'b1;
        frame_start  = 1'b0;
        word_strobe  = 1'b0;
        word_data    = '0;
        draw_errors  = 0;
        zoom_errors  = 0;
        other_errors = 0;
        entries_run  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        fd = $fopen("tests/obj_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/obj_input.txt");
            other_errors++;
        end else begin
            items = 0;
            while (!$feof(fd) && items < MAX_ITEMS) begin
                tok = '0;
                rc  = $fscanf(fd, "%s", tok);
                if (rc == 1) begin
                    if (tok == TOK_W'("#")) begin
                        rc = $fgets(rest, fd);
                    end else if (tok == TOK_W'("frame")) begin
                        pulse_frame();
                    end else if (tok == TOK_W'("entry")) begin
                        run_entry(fd);
                    end else begin
                        $display("unknown keyword %0s in the stimulus file", tok);
                        other_errors++;
                    end
                end
                items++;
            end
            $fclose(fd);
        end
        if (entries_run == 0) begin
            $display("the stimulus file held no entries");
            other_errors++;
        end

        $display("%0d entries, %0d draw errors, %0d zoom errors, %0d other errors",
                 entries_run, draw_errors, zoom_errors, other_errors);
        if (draw_errors + zoom_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tests/obj_input.txt */
# entry name w0 w1 w2 w3 w4 w5 w6 w7 visible tile colour screen_x screen_y flip_x flip_y bpp6
# then row_mask col_mask row_count col_count; all numbers hex, frame pulses frame_start
frame
# absolute sprites
entry abs_a 0123 0000 c064 0032 0115 0000 0000 0000 1 0123 15 064 032 1 0 0 ffff ffff 10 10
entry abs_b 1fff 0000 c1e0 00f0 02a7 0000 0000 0000 1 1fff a7 1e0 0f0 0 1 0 ffff ffff 10 10
frame
# master latch, master scroll, extra latch, master plus extra
entry latch_m 0001 0000 a010 0008 0002 0000 0000 0000 1 0001 02 010 008 0 0 0 ffff ffff 10 10
entry scroll_m 0002 0000 4050 0020 0003 0000 0000 0000 1 0002 03 060 028 0 0 0 ffff ffff 10 10
entry latch_e 0003 0000 5004 0006 0004 0000 0000 0000 1 0003 04 014 00e 0 0 0 ffff ffff 10 10
entry scroll_me 0004 0000 0040 0030 0005 0000 0000 0000 1 0004 05 054 03e 0 0 0 ffff ffff 10 10
frame
entry extra_clr 0004 0000 0040 0030 0005 0000 0000 0000 1 0004 05 050 038 0 0 0 ffff ffff 10 10
frame
# zoom masks and a sequence with inc_x and a continued column phase
entry zoom_80 0010 8080 c020 0020 0010 0000 0000 0000 1 0010 10 020 020 0 0 0 00ff 00ff 08 08
entry zoom_f0 0011 f080 c030 0030 0011 0000 0000 0000 1 0011 11 030 030 0 0 0 0001 00ff 01 08
entry seq_head 0020 0088 c040 0050 0820 0000 0000 0000 1 0020 20 040 050 0 0 0 ffff 007f 10 07
entry seq_inc_x 0021 0000 c000 0000 8021 0000 0000 0000 1 0021 21 047 050 0 0 0 ffff 00ff 10 08
frame
# skip rules
entry zero_tile 0000 0000 c010 0010 0030 0000 0000 0000 0 0000 30 010 010 0 0 0 ffff ffff 10 10
entry x_over 0005 0000 c1e1 0010 0030 0000 0000 0000 0 0005 30 1e1 010 0 0 0 ffff ffff 10 10
entry y_over 0005 0000 c010 00f1 0030 0000 0000 0000 0 0005 30 010 0f1 0 0 0 ffff ffff 10 10
entry disable_cmd 0006 0000 c010 8010 0031 1000 0000 0000 0 0006 31 010 010 0 0 0 ffff ffff 10 10
entry still_off 0007 0000 c020 0020 0032 0000 0000 0000 0 0007 32 020 020 0 0 0 ffff ffff 10 10
frame
entry enabled 0007 0000 c020 0020 0032 0000 0000 0000 1 0007 32 020 020 0 0 0 ffff ffff 10 10
# flip screen and 6-bpp
entry flip_cmd 0008 0000 c010 8010 0140 2100 0000 0000 1 0008 40 1e0 0e0 0 1 1 ffff ffff 10 10
entry flip_spr 0009 0000 c064 0032 0041 0000 0000 0000 1 0009 41 18c 0be 1 1 1 ffff ffff 10 10
frame
entry flip_clr 000a 0000 c064 0032 0041 0000 0000 0000 1 000a 41 064 032 0 0 0 ffff ffff 10 10

/* filelist.f */
rtl/obj_pkg.sv
rtl/obj_entry_decode.sv
rtl/obj_position_eval.sv
rtl/obj_zoom_calc.sv
rtl/obj_draw_result.sv
rtl/obj_engine_top.sv
tests/obj_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module obj_tb \
    -f filelist.f -o obj_sim > build.log 2>&1 \
    && ./obj_dir/obj_sim > sim.log 2>&1 \
    || echo "build or run returned an error, see build.log and sim.log"
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
